// ==== logic/erosionPkg.sv ====
// Widths, row types and pipeline structs shared by every module of the erosion engine
`default_nettype none

package erosionPkg;

	//////////////////////////////
	// Geometry
	//////////////////////////////
	localparam int PixelBits = 3;
	localparam int PixelsPerRow = 128;
	localparam int RowBits = PixelBits * PixelsPerRow;
	localparam int MaxRows = 128;
	localparam int ElementBits = 9 * PixelBits;
	// Row with one zero pixel of padding on each side
	localparam int PaddedBits = RowBits + 2 * PixelBits;
	localparam logic [PixelBits-1:0] PixelOnes = '1;

	//////////////////////////////
	// Basic types
	//////////////////////////////
	typedef logic [PixelBits-1:0] pixel_t;
	// Pixel 0 sits in the top bits
	typedef logic [RowBits-1:0] row_t;
	typedef logic [$clog2(MaxRows)-1:0] rowAddr_t;
	typedef logic [$clog2(MaxRows):0] rowCount_t;
	// Top, mid, bottom window rows; each left, centre, right
	typedef logic [ElementBits-1:0] element_t;

	//////////////////////////////
	// Pipeline structs
	//////////////////////////////
	typedef struct packed {
		element_t element;
		rowCount_t rowCount;
	} erosionCfg_t;

	typedef struct packed {
		logic valid;
		logic flush;
		row_t data;
	} rowBeat_t;

	typedef struct packed {
		logic valid;
		logic last;
		rowAddr_t rowIdx;
		row_t top;
		row_t mid;
		row_t bot;
	} window_t;

	typedef struct packed {
		logic valid;
		logic last;
		rowAddr_t rowIdx;
		row_t data;
	} result_t;

	typedef enum logic [2:0] {Idle, Read, Flush, Drain, Ack} fetchState_t;

	// Configuration seen after reset
	localparam erosionCfg_t DefaultCfg = '{element: '0, rowCount: rowCount_t'(MaxRows)};

endpackage

`default_nettype wire

// ==== logic/erosionConfig.sv ====
// Holds the structuring element and row count behind a req/ack port and snapshots them per frame
`timescale 1ns/1ps
`default_nettype none

module erosionConfig
(
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic cfgReq_i,
	input wire erosionPkg::erosionCfg_t cfgData_i,
	output logic cfgAck_o,
	input wire logic frameIdle_i,
	input wire logic frameStart_i,
	output erosionPkg::erosionCfg_t frameCfg_o
);
	import erosionPkg::*;

	erosionCfg_t staging;
	erosionCfg_t active;

	//////////////////////////////
	// Config handshake
	//////////////////////////////
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			cfgAck_o <= 1'b0;
			staging <= DefaultCfg;
			active <= DefaultCfg;
		end
		else
		begin
			if (!cfgReq_i)
			begin
				cfgAck_o <= 1'b0;
			end
			else if (!cfgAck_o && frameIdle_i)
			begin
				// New value only lands between frames
				staging <= cfgData_i;
				cfgAck_o <= 1'b1;
			end

			// Freeze the frame's settings at its start
			if (frameStart_i)
			begin
				active <= staging;
			end
		end
	end

	assign frameCfg_o = active;

endmodule

`default_nettype wire

// ==== logic/rowFetch.sv ====
// Frame handshake FSM that sweeps the input row memory and feeds row beats to the line buffer
`timescale 1ns/1ps
`default_nettype none

module rowFetch
(
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic frameReq_i,
	output logic frameAck_o,
	output logic frameIdle_o,
	output logic frameStart_o,
	input wire erosionPkg::rowCount_t rowCount_i,
	output logic rdEn_o,
	output erosionPkg::rowAddr_t rdAddr_o,
	input wire erosionPkg::row_t rdData_i,
	output erosionPkg::rowBeat_t beat_o,
	input wire logic frameDone_i
);
	import erosionPkg::*;

	fetchState_t state;
	rowAddr_t lastAddr;
	logic rdValid;
	logic flushValid;

	assign lastAddr = rowAddr_t'(rowCount_i - rowCount_t'(1));

	// No read in the frameStart cycle while the snapshot settles
	assign rdEn_o = (state == Read) && !frameStart_o;
	assign frameIdle_o = (state == Idle);
	assign frameAck_o = (state == Ack);

	//////////////////////////////
	// Frame FSM
	//////////////////////////////
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= Idle;
			frameStart_o <= 1'b0;
			rdAddr_o <= '0;
			rdValid <= 1'b0;
			flushValid <= 1'b0;
		end
		else
		begin
			frameStart_o <= 1'b0;
			rdValid <= rdEn_o;
			flushValid <= (state == Flush);
			unique case (state)
				Idle:
				begin
					if (frameReq_i)
					begin
						state <= Read;
						frameStart_o <= 1'b1;
						rdAddr_o <= '0;
					end
				end
				Read:
				begin
					if (rdEn_o)
					begin
						if (rdAddr_o == lastAddr)
							state <= Flush;
						else
							rdAddr_o <= rdAddr_o + 1'b1;
					end
				end
				Flush: state <= Drain;
				Drain:
				begin
					if (frameDone_i)
						state <= Ack;
				end
				Ack:
				begin
					if (!frameReq_i)
						state <= Idle;
				end
				default: state <= Idle;
			endcase
		end
	end

	// Read data arrives one cycle after rdEn and the flush beat is a zero row
	assign beat_o = '{
		valid: rdValid | flushValid,
		flush: flushValid,
		data: flushValid ? row_t'(0) : rdData_i
	};

endmodule

`default_nettype wire

// ==== logic/lineBuffer.sv ====
// Three-row shift buffer that turns row beats into erosion windows with row index and last flag
`timescale 1ns/1ps
`default_nettype none

module lineBuffer
(
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic frameStart_i,
	input wire erosionPkg::rowBeat_t beat_i,
	output erosionPkg::window_t win_o
);
	import erosionPkg::*;

	row_t topRow;
	row_t midRow;
	row_t botRow;
	logic seenFirst;
	logic winValid;
	logic winLast;
	rowAddr_t idxCnt;
	rowAddr_t winIdx;

	//////////////////////////////
	// Window control
	//////////////////////////////
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			seenFirst <= 1'b0;
			winValid <= 1'b0;
			winLast <= 1'b0;
			idxCnt <= '0;
			winIdx <= '0;
		end
		else if (frameStart_i)
		begin
			seenFirst <= 1'b0;
			winValid <= 1'b0;
			winLast <= 1'b0;
			idxCnt <= '0;
		end
		else
		begin
			// Centre holds a real row from the second beat on
			winValid <= beat_i.valid && seenFirst;
			winLast <= beat_i.valid && seenFirst && beat_i.flush;
			if (beat_i.valid)
			begin
				seenFirst <= 1'b1;
				if (seenFirst)
				begin
					winIdx <= idxCnt;
					idxCnt <= idxCnt + 1'b1;
				end
			end
		end
	end

	// Zero rows at frame start give the zero row above row 0
	always_ff @(posedge clk_i)
	begin
		if (frameStart_i)
		begin
			topRow <= '0;
			midRow <= '0;
			botRow <= '0;
		end
		else if (beat_i.valid)
		begin
			topRow <= midRow;
			midRow <= botRow;
			botRow <= beat_i.data;
		end
	end

	assign win_o = '{valid: winValid, last: winLast, rowIdx: winIdx,
		top: topRow, mid: midRow, bot: botRow};

endmodule

`default_nettype wire

// ==== logic/erosionCore.sv ====
// Per-pixel 3x3 match erosion of one window row with a registered result stage
`timescale 1ns/1ps
`default_nettype none

module erosionCore
(
	input wire logic clk_i,
	input wire logic rst_i,
	input wire erosionPkg::element_t element_i,
	input wire erosionPkg::window_t win_i,
	output erosionPkg::result_t res_o
);
	import erosionPkg::*;

	logic [PaddedBits-1:0] topPad;
	logic [PaddedBits-1:0] midPad;
	logic [PaddedBits-1:0] botPad;
	row_t eroded;
	logic validQ;
	logic lastQ;
	rowAddr_t idxQ;
	row_t dataQ;

	// Zero pixel beyond the left and right edges
	assign topPad = {pixel_t'(0), win_i.top, pixel_t'(0)};
	assign midPad = {pixel_t'(0), win_i.mid, pixel_t'(0)};
	assign botPad = {pixel_t'(0), win_i.bot, pixel_t'(0)};

	//////////////////////////////
	// Pixel compare array
	//////////////////////////////
	for (genvar p = 0; p < PixelsPerRow; p++)
	begin : genPixel
		element_t hood;
		pixel_t centre;
		assign hood = {topPad[PaddedBits-1-p*PixelBits -: 3*PixelBits],
			midPad[PaddedBits-1-p*PixelBits -: 3*PixelBits],
			botPad[PaddedBits-1-p*PixelBits -: 3*PixelBits]};
		assign centre = win_i.mid[RowBits-1-p*PixelBits -: PixelBits];
		assign eroded[RowBits-1-p*PixelBits -: PixelBits] = (hood == element_i) ? centre : PixelOnes;
	end

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			validQ <= 1'b0;
			lastQ <= 1'b0;
		end
		else
		begin
			validQ <= win_i.valid;
			lastQ <= win_i.valid && win_i.last;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (win_i.valid)
		begin
			idxQ <= win_i.rowIdx;
			dataQ <= eroded;
		end
	end

	assign res_o = '{valid: validQ, last: lastQ, rowIdx: idxQ, data: dataQ};

endmodule

`default_nettype wire

// ==== logic/rowWriter.sv ====
// Turns each eroded row into one output memory write and flags the end of the frame
`timescale 1ns/1ps
`default_nettype none

module rowWriter
(
	input wire logic clk_i,
	input wire logic rst_i,
	input wire erosionPkg::result_t res_i,
	output logic wrEn_o,
	output erosionPkg::rowAddr_t wrAddr_o,
	output erosionPkg::row_t wrData_o,
	output logic frameDone_o
);
	import erosionPkg::*;

	//////////////////////////////
	// Write strobe and done pulse
	//////////////////////////////
	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			wrEn_o <= 1'b0;
			frameDone_o <= 1'b0;
		end
		else
		begin
			wrEn_o <= res_i.valid;
			// Done rides along with the last row's write
			frameDone_o <= res_i.valid && res_i.last;
		end
	end

	// The row index is the memory row of the write
	always_ff @(posedge clk_i)
	begin
		if (res_i.valid)
		begin
			wrAddr_o <= rowAddr_t'(res_i.rowIdx);
			wrData_o <= row_t'(res_i.data);
		end
	end

endmodule

`default_nettype wire

// ==== logic/erosionTop.sv ====
// Top of the erosion engine joining config, fetch, line buffer, erosion core and writer
`timescale 1ns/1ps
`default_nettype none

module erosionTop
(
	input wire logic clk_i,
	input wire logic rst_i,
	// Frame port
	input wire logic frameReq_i,
	output logic frameAck_o,
	// Config port
	input wire logic cfgReq_i,
	input wire erosionPkg::erosionCfg_t cfgData_i,
	output logic cfgAck_o,
	// Input row memory
	output logic rdEn_o,
	output erosionPkg::rowAddr_t rdAddr_o,
	input wire erosionPkg::row_t rdData_i,
	// Output row memory
	output logic wrEn_o,
	output erosionPkg::rowAddr_t wrAddr_o,
	output erosionPkg::row_t wrData_o
);
	import erosionPkg::*;

	logic frameIdle;
	logic frameStart;
	logic frameDone;
	erosionCfg_t frameCfg;
	rowBeat_t beat;
	window_t win;
	result_t res;

	//////////////////////////////
	// Control side
	//////////////////////////////
	erosionConfig i_erosionConfig
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.cfgReq_i(cfgReq_i),
		.cfgData_i(cfgData_i),
		.cfgAck_o(cfgAck_o),
		.frameIdle_i(frameIdle),
		.frameStart_i(frameStart),
		.frameCfg_o(frameCfg)
	);

	rowFetch i_rowFetch
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.frameReq_i(frameReq_i),
		.frameAck_o(frameAck_o),
		.frameIdle_o(frameIdle),
		.frameStart_o(frameStart),
		.rowCount_i(frameCfg.rowCount),
		.rdEn_o(rdEn_o),
		.rdAddr_o(rdAddr_o),
		.rdData_i(rdData_i),
		.beat_o(beat),
		.frameDone_i(frameDone)
	);

	//////////////////////////////
	// Pixel path
	//////////////////////////////
	lineBuffer i_lineBuffer
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.frameStart_i(frameStart),
		.beat_i(beat),
		.win_o(win)
	);

	erosionCore i_erosionCore
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.element_i(frameCfg.element),
		.win_i(win),
		.res_o(res)
	);

	rowWriter i_rowWriter
	(
		.clk_i(clk_i),
		.rst_i(rst_i),
		.res_i(res),
		.wrEn_o(wrEn_o),
		.wrAddr_o(wrAddr_o),
		.wrData_o(wrData_o),
		.frameDone_o(frameDone)
	);

endmodule

`default_nettype wire

// ==== tests/erosionTop_props.sv ====
// Frame and config handshake assertions plus the write window, bound into the engine top level
`timescale 1ns/1ps
`default_nettype none

module erosionTopProps
(
	input wire logic clk_i,
	input wire logic rst_i,
	input wire logic frameReq_i,
	input wire logic frameAck_i,
	input wire logic frameIdle_i,
	input wire logic cfgReq_i,
	input wire logic cfgAck_i,
	input wire logic wrEn_i
);

	//////////////////////////////
	// Frame handshake
	//////////////////////////////
	ackRiseWithReq: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(frameAck_i) |-> frameReq_i)
		else $error("Frame ack rose without a frame request");

	ackFallAfterReq: assert property (@(posedge clk_i) disable iff (rst_i)
		$fell(frameAck_i) |-> !$past(frameReq_i))
		else $error("Frame ack fell while the request was still high");

	// Writes only while a frame is being processed
	writeInFrame: assert property (@(posedge clk_i) disable iff (rst_i)
		!(wrEn_i && (frameAck_i || frameIdle_i)))
		else $error("Output write outside the frame window");

	//////////////////////////////
	// Config handshake
	//////////////////////////////
	cfgAckRise: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(cfgAck_i) |-> cfgReq_i)
		else $error("Config ack rose without a config request");

	cfgAckDrop: assert property (@(posedge clk_i) disable iff (rst_i)
		(cfgAck_i && !cfgReq_i) |=> !cfgAck_i)
		else $error("Config ack held after the request fell");

endmodule

bind erosionTop erosionTopProps i_erosionTopProps
(
	.clk_i(clk_i),
	.rst_i(rst_i),
	.frameReq_i(frameReq_i),
	.frameAck_i(frameAck_o),
	.frameIdle_i(frameIdle),
	.cfgReq_i(cfgReq_i),
	.cfgAck_i(cfgAck_o),
	.wrEn_i(wrEn_o)
);

`default_nettype wire

// ==== tests/erosionTb.sv ====
// Self-checking testbench for the erosion engine; runs the stimulus table against a reference model
`timescale 1ns/1ps
`default_nettype none

module erosionTb;
	import erosionPkg::*;

	typedef enum logic [1:0] {ImgRandom, ImgZero, ImgConst} imageKind_t;

	typedef struct packed {
		logic fromWindow;
		element_t element;
		rowCount_t rowCount;
		imageKind_t kind;
		logic midCfg;
	} testCase_t;

	// fromWindow, element, rowCount, image kind, config request mid-frame
	testCase_t tests [7] = '{
		'{1'b1, element_t'(0), rowCount_t'(128), ImgRandom, 1'b0},
		'{1'b1, element_t'(0), rowCount_t'(5), ImgRandom, 1'b0},
		'{1'b1, element_t'(0), rowCount_t'(1), ImgRandom, 1'b0},
		'{1'b0, element_t'(0), rowCount_t'(16), ImgZero, 1'b0},
		'{1'b0, element_t'(1), rowCount_t'(16), ImgZero, 1'b0},
		'{1'b1, element_t'(0), rowCount_t'(8), ImgConst, 1'b0},
		'{1'b1, element_t'(0), rowCount_t'(12), ImgRandom, 1'b1}
	};

	logic clk;
	logic rst;
	logic frameReq;
	logic frameAck;
	logic cfgReq;
	erosionCfg_t cfgData;
	logic cfgAck;
	logic rdEn;
	rowAddr_t rdAddr;
	row_t rdData;
	logic wrEn;
	rowAddr_t wrAddr;
	row_t wrData;

	row_t inMem [MaxRows];
	row_t outMem [MaxRows];
	rowAddr_t writeLog [$];
	rowAddr_t readLog [$];
	int lateWrites;
	int errors;
	int failedTests;
	logic [15:0] lfsr;

	erosionTop i_erosionTop
	(
		.clk_i(clk),
		.rst_i(rst),
		.frameReq_i(frameReq),
		.frameAck_o(frameAck),
		.cfgReq_i(cfgReq),
		.cfgData_i(cfgData),
		.cfgAck_o(cfgAck),
		.rdEn_o(rdEn),
		.rdAddr_o(rdAddr),
		.rdData_i(rdData),
		.wrEn_o(wrEn),
		.wrAddr_o(wrAddr),
		.wrData_o(wrData)
	);

	// 20 ns clock
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Row memory models
	//////////////////////////////
	// Read request sampled mid-cycle and data driven just after the next edge
	initial
	begin : inputMemory
		logic pending;
		rowAddr_t addrQ;
		rdData = '0;
		forever
		begin
			@(negedge clk);
			pending = rdEn;
			addrQ = rdAddr;
			if (rdEn)
				readLog.push_back(rdAddr);
			@(posedge clk);
			#2;
			if (pending)
				rdData = inMem[addrQ];
		end
	end

	always @(negedge clk)
	begin
		if (wrEn)
		begin
			outMem[wrAddr] = wrData;
			writeLog.push_back(wrAddr);
			if (frameAck)
				lateWrites++;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// Zero outside the image on every side
	function automatic pixel_t pixelAt(input int r, input int p, input int n);
		if (r < 0 || r >= n || p < 0 || p >= PixelsPerRow)
			return '0;
		return inMem[r][RowBits-1-p*PixelBits -: PixelBits];
	endfunction

	function automatic element_t hoodAt(input int r, input int p, input int n);
		return {pixelAt(r - 1, p - 1, n), pixelAt(r - 1, p, n), pixelAt(r - 1, p + 1, n),
			pixelAt(r, p - 1, n), pixelAt(r, p, n), pixelAt(r, p + 1, n),
			pixelAt(r + 1, p - 1, n), pixelAt(r + 1, p, n), pixelAt(r + 1, p + 1, n)};
	endfunction

	function automatic row_t expRow(input int r, input element_t el, input int n);
		row_t outRow;
		int p;
		for (p = 0; p < PixelsPerRow; p++)
			outRow[RowBits-1-p*PixelBits -: PixelBits] = (hoodAt(r, p, n) == el) ?
				pixelAt(r, p, n) : 3'd7;
		return outRow;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic checkRow(input row_t got, input row_t exp, input int r);
		int p;
		int bad;
		bad = -1;
		for (p = PixelsPerRow - 1; p >= 0; p--)
			if (got[RowBits-1-p*PixelBits -: PixelBits] !== exp[RowBits-1-p*PixelBits -: PixelBits])
				bad = p;
		if (bad >= 0)
		begin
			errors++;
			$display("ERROR at %0t: row %0d pixel %0d is %0d, expected %0d", $time, r, bad,
				got[RowBits-1-bad*PixelBits -: PixelBits], exp[RowBits-1-bad*PixelBits -: PixelBits]);
		end
	endtask

	task automatic checkAddr(input rowAddr_t got, input rowAddr_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkCount(input rowCount_t got, input rowCount_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////
	task automatic fillImage(input imageKind_t kind);
		int r;
		int b;
		row_t img;
		for (r = 0; r < MaxRows; r++)
		begin
			case (kind)
				ImgRandom:
				begin
					for (b = 0; b < RowBits; b++)
					begin
						lfsr = lfsrNext(lfsr);
						img[b] = lfsr[0];
					end
				end
				ImgConst: img = {PixelsPerRow{3'd5}};
				default: img = '0;
			endcase
			inMem[r] = img;
		end
	endtask

	// Unwritten rows keep an address-dependent pattern
	task automatic clearOutput();
		int a;
		writeLog.delete();
		readLog.delete();
		lateWrites = 0;
		for (a = 0; a < MaxRows; a++)
			outMem[a] = {48{8'(a) ^ 8'h5A}};
	endtask

	// Waits on frame ack or config ack and can flag any config ack on the way
	task automatic waitSignal(input logic useCfg, input logic level, input int maxCycles,
		input logic guardCfg, output logic ok);
		int c;
		ok = 1'b0;
		c = 0;
		while (!ok && c < maxCycles)
		begin
			@(negedge clk);
			c++;
			if (guardCfg && cfgAck)
			begin
				errors++;
				$display("ERROR at %0t: config acknowledged while a frame is running", $time);
			end
			if ((useCfg ? cfgAck : frameAck) == level)
				ok = 1'b1;
		end
	endtask

	task automatic sendCfg(input element_t el, input rowCount_t n);
		@(posedge clk);
		#2;
		cfgData = '{element: el, rowCount: n};
		cfgReq = 1'b1;
	endtask

	task automatic closeCfg(output logic ok);
		waitSignal(1'b1, 1'b1, 20, 1'b0, ok);
		if (!ok)
		begin
			errors++;
			$display("The config ack never arrived");
			return;
		end
		@(posedge clk);
		#2;
		cfgReq = 1'b0;
		waitSignal(1'b1, 1'b0, 20, 1'b0, ok);
		if (!ok)
		begin
			errors++;
			$display("The config ack stayed high after the request fell");
		end
	endtask

	task automatic runFrame(input logic midCfg, input element_t newEl, input rowCount_t n,
		output logic ok);
		@(posedge clk);
		#2;
		frameReq = 1'b1;
		if (midCfg)
		begin
			@(posedge clk);
			sendCfg(newEl, n);
		end
		waitSignal(1'b0, 1'b1, int'(n) + 20, midCfg, ok);
		if (!ok)
		begin
			errors++;
			$display("The frame ack never rose");
			return;
		end
		// Ack must hold while the request stays high
		repeat (3)
		begin
			@(negedge clk);
			checkFlag(frameAck, 1'b1, "frame ack with request held");
			if (midCfg)
				checkFlag(cfgAck, 1'b0, "config ack during frame");
		end
		@(posedge clk);
		#2;
		frameReq = 1'b0;
		waitSignal(1'b0, 1'b0, 4, midCfg, ok);
		if (!ok)
		begin
			errors++;
			$display("The frame ack stayed high after the request fell");
		end
	endtask

	task automatic checkFrame(input element_t el, input rowCount_t n);
		int i;
		checkCount(rowCount_t'(readLog.size()), n, "read count");
		for (i = 0; i < readLog.size(); i++)
			checkAddr(readLog[i], rowAddr_t'(i), "read address");
		checkCount(rowCount_t'(writeLog.size()), n, "write count");
		checkCount(rowCount_t'(lateWrites), rowCount_t'(0), "writes after frame ack");
		for (i = 0; i < writeLog.size(); i++)
			checkAddr(writeLog[i], rowAddr_t'(i), "write address");
		for (i = 0; i < int'(n); i++)
			checkRow(outMem[i], expRow(i, el, int'(n)), i);
	endtask

	task automatic runTest(input int t);
		testCase_t tc;
		element_t el;
		element_t newEl;
		logic ok;
		int errBefore;
		tc = tests[t];
		errBefore = errors;
		fillImage(tc.kind);
		el = tc.fromWindow ? hoodAt(int'(tc.rowCount) / 2, PixelsPerRow / 2, int'(tc.rowCount)) :
			tc.element;
		newEl = ~el;
		sendCfg(el, tc.rowCount);
		closeCfg(ok);
		clearOutput();
		if (ok)
			runFrame(tc.midCfg, newEl, tc.rowCount, ok);
		if (ok)
			checkFrame(el, tc.rowCount);
		// The pending request lands after the frame and the next frame runs on the new element
		if (ok && tc.midCfg)
		begin
			closeCfg(ok);
			clearOutput();
			if (ok)
				runFrame(1'b0, newEl, tc.rowCount, ok);
			if (ok)
				checkFrame(newEl, tc.rowCount);
		end
		if (errors != errBefore)
			failedTests++;
		$display("test %0d, %0d rows: %s", t, tc.rowCount, (errors == errBefore) ? "ok" : "wrong");
	endtask

	// Watchdog sized from the table
	initial
	begin : watchdog
		int budget;
		budget = 8 + 10;
		foreach (tests[i])
			budget += (tests[i].midCfg ? 2 : 1) * (int'(tests[i].rowCount) + 20);
		repeat (budget) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run is stuck", budget);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		frameReq = 1'b0;
		cfgReq = 1'b0;
		cfgData = '0;
		rst = 1'b1;
		lfsr = 16'd59;
		errors = 0;
		failedTests = 0;
		lateWrites = 0;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		checkFlag(frameAck, 1'b0, "frame ack after reset");
		checkFlag(cfgAck, 1'b0, "config ack after reset");
		checkFlag(rdEn, 1'b0, "read enable after reset");
		checkFlag(wrEn, 1'b0, "write enable after reset");
		for (int t = 0; t < $size(tests); t++)
			runTest(t);
		$display("%0d tests, %0d failed, %0d errors", $size(tests), failedTests, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
logic/erosionPkg.sv
logic/erosionConfig.sv
logic/rowFetch.sv
logic/lineBuffer.sv
logic/erosionCore.sv
logic/rowWriter.sv
logic/erosionTop.sv
tests/erosionTop_props.sv
tests/erosionTb.sv

// ==== Makefile ====
# Verilator build and run for the erosion engine testbench

VERILATOR ?= verilator
TOP ?= erosionTb
FILELIST ?= all.f
BUILD_DIR ?= build
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
